/* src/lsu_pkg.sv */
package lsu_pkg;

    // data and byte address word.
    typedef logic [31:0] word_t;

    // operation kind on the issue port.
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } mem_type_t;

    // words in the data memory.
    localparam int DMEM_WORDS = 256;

    // access cycles with pready low before the memory answers.
    localparam int SRAM_WAIT = 1;

    // word index width into the memory array.
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // wait counter width to reach SRAM_WAIT.
    localparam int WAIT_CNT_W = $clog2(SRAM_WAIT + 2);

endpackage

/* src/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if import lsu_pkg::*; ();

    // request side, from the load/store unit.
    word_t dmem_addr;
    word_t dmem_store;
    logic  dmem_ren;
    logic  dmem_wen;

    // response side, from the bridge.
    word_t dmem_load;
    logic  dhit;
    logic  derr;

    modport lsu (
        output dmem_addr, dmem_store, dmem_ren, dmem_wen,
        input  dmem_load, dhit, derr
    );

    modport bridge (
        input  dmem_addr, dmem_store, dmem_ren, dmem_wen,
        output dmem_load, dhit, derr
    );

endinterface

/* src/apb_if.sv */
`timescale 1ns/1ps

interface apb_if import lsu_pkg::*; ();

    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t paddr;
    word_t pwdata;
    word_t prdata;
    logic  pready;
    logic  pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

/* src/scalar_ls_unit.sv */
`timescale 1ns/1ps

module scalar_ls_unit import lsu_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    dmem_if.lsu       dls,
    input  mem_type_t mem_type,
    input  word_t     rs1,
    input  word_t     rs2,
    input  word_t     imm,
    output logic      done,
    output word_t     load_data
);

    typedef enum logic {
        idle,
        latched
    } state_t;

    state_t state;
    state_t next_state;

    word_t addr;
    word_t addr_q;
    word_t store_q;
    logic  is_load;
    logic  is_store;
    logic  ren_q;
    logic  wen_q;

    // byte address wraps at 2^32.
    assign addr     = rs1 + imm;
    assign is_load  = (mem_type == LOAD);
    assign is_store = (mem_type == STORE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= idle;
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else begin
            state <= next_state;
            if (state == idle) begin
                ren_q <= is_load;
                wen_q <= is_store;
            end
        end
    end

    // request payload captured while idle.
    always_ff @(posedge CLK) begin
        if (state == idle) begin
            addr_q  <= addr;
            store_q <= rs2;
        end
    end

    always_comb begin
        next_state     = state;
        dls.dmem_addr  = '0;
        dls.dmem_store = '0;
        dls.dmem_ren   = 1'b0;
        dls.dmem_wen   = 1'b0;
        done           = 1'b0;
        load_data      = '0;
        case (state)
            idle: begin
                // request goes out in the same cycle as the issue.
                if (is_load || is_store) begin
                    dls.dmem_addr = addr;
                    dls.dmem_ren  = is_load;
                    dls.dmem_wen  = is_store;
                    if (is_store) begin
                        dls.dmem_store = rs2;
                    end
                    next_state = latched;
                end
            end
            latched: begin
                dls.dmem_addr  = addr_q;
                dls.dmem_store = store_q;
                dls.dmem_ren   = ren_q;
                dls.dmem_wen   = wen_q;
                // hold the request until dhit.
                if (dls.dhit) begin
                    dls.dmem_ren = 1'b0;
                    dls.dmem_wen = 1'b0;
                    done         = 1'b1;
                    if (ren_q) begin
                        load_data = dls.dmem_load;
                    end
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

endmodule

/* src/dmem_apb_master.sv */
`timescale 1ns/1ps

module dmem_apb_master import lsu_pkg::*; (
    input  logic   CLK,
    input  logic   nRST,
    dmem_if.bridge dm,
    apb_if.master  apb
);

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } state_t;

    state_t state;
    state_t next_state;

    word_t addr_q;
    word_t wdata_q;
    logic  write_q;
    logic  req;

    assign req = dm.dmem_ren | dm.dmem_wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= idle;
            write_q <= 1'b0;
        end else begin
            state <= next_state;
            if (state == idle && req) begin
                write_q <= dm.dmem_wen;
            end
        end
    end

    // transfer payload held from setup to the end of access.
    always_ff @(posedge CLK) begin
        if (state == idle && req) begin
            addr_q  <= dm.dmem_addr;
            wdata_q <= dm.dmem_store;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (req) begin
                    next_state = setup;
                end
            end
            setup: next_state = access;
            access: begin
                if (apb.pready) begin
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    assign apb.psel    = (state != idle);
    assign apb.penable = (state == access);
    assign apb.pwrite  = write_q;
    assign apb.paddr   = addr_q;
    assign apb.pwdata  = wdata_q;

    // completion is the access cycle with pready high.
    assign dm.dhit      = (state == access) && apb.pready;
    assign dm.dmem_load = apb.prdata;
    assign dm.derr      = dm.dhit && apb.pslverr;

endmodule

/* src/apb_sram.sv */
`timescale 1ns/1ps

module apb_sram import lsu_pkg::*; (
    input  logic CLK,
    input  logic nRST,
    apb_if.slave apb
);

    word_t mem [DMEM_WORDS];

    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic [DMEM_IDX_W-1:0] idx;
    logic                  in_access;
    logic                  in_range;

    assign in_access = apb.psel && apb.penable;
    assign in_range  = (apb.paddr < word_t'(DMEM_WORDS * 4));

    // low two address bits are ignored.
    assign idx = apb.paddr[DMEM_IDX_W+1:2];

    assign apb.pready  = in_access && (wait_cnt == WAIT_CNT_W'(SRAM_WAIT));
    assign apb.pslverr = apb.pready && !in_range;
    assign apb.prdata  = (apb.pready && in_range && !apb.pwrite) ? mem[idx] : '0;

    // counts access cycles until pready.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!in_access || apb.pready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (apb.pready && apb.pwrite && in_range) begin
            mem[idx] <= apb.pwdata;
        end
    end

endmodule

/* src/ls_subsystem.sv */
`timescale 1ns/1ps

module ls_subsystem import lsu_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  mem_type_t mem_type,
    input  word_t     rs1,
    input  word_t     rs2,
    input  word_t     imm,
    output logic      done,
    output word_t     load_data,
    output logic      err
);

    dmem_if dmem ();
    apb_if  apb ();

    scalar_ls_unit lsu_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .dls       (dmem.lsu),
        .mem_type  (mem_type),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .done      (done),
        .load_data (load_data)
    );

    dmem_apb_master bridge_i (
        .CLK  (CLK),
        .nRST (nRST),
        .dm   (dmem.bridge),
        .apb  (apb.master)
    );

    apb_sram sram_i (
        .CLK  (CLK),
        .nRST (nRST),
        .apb  (apb.slave)
    );

    // error only in the completion cycle.
    assign err = dmem.derr;

endmodule

/* sim/ls_subsystem_properties.sv */
`timescale 1ns/1ps

module ls_subsystem_properties import lsu_pkg::*; (
    input logic  CLK,
    input logic  nRST,
    input logic  psel,
    input logic  penable,
    input logic  pwrite,
    input word_t paddr,
    input word_t pwdata,
    input logic  pready,
    input logic  dhit
);

    int unsigned violations = 0;

    penable_needs_psel: assert property (@(posedge CLK) disable iff (!nRST)
        penable |-> psel)
        else begin
            violations++;
            $error("penable high while psel is low");
        end

    // one setup cycle then access.
    setup_then_access: assert property (@(posedge CLK) disable iff (!nRST)
        (psel && !penable) |=> (psel && penable))
        else begin
            violations++;
            $error("setup phase not followed by access phase");
        end

    payload_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (psel && !(penable && pready)) |=>
            ($stable(paddr) && $stable(pwdata) && $stable(pwrite)))
        else begin
            violations++;
            $error("address or write data changed before pready");
        end

    dhit_on_completion: assert property (@(posedge CLK) disable iff (!nRST)
        dhit |-> (psel && penable && pready))
        else begin
            violations++;
            $error("dhit outside an access cycle with pready");
        end

endmodule

bind dmem_apb_master ls_subsystem_properties props_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .psel    (apb.psel),
    .penable (apb.penable),
    .pwrite  (apb.pwrite),
    .paddr   (apb.paddr),
    .pwdata  (apb.pwdata),
    .pready  (apb.pready),
    .dhit    (dm.dhit)
);

/* sim/ls_subsystem_tb.sv */
`timescale 1ns/1ps

module ls_subsystem_tb import lsu_pkg::*; ();

    localparam int          DONE_TIMEOUT = 50;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic      CLK;
    logic      nRST;
    mem_type_t mem_type;
    word_t     rs1;
    word_t     rs2;
    word_t     imm;
    logic      done;
    word_t     load_data;
    logic      err;

    logic [31:0] lfsr_state;
    word_t       ref_mem [DMEM_WORDS];
    string       test_name;
    int          errors;
    int          start_errors;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;
    word_t       last_data;
    logic        last_err;

    ls_subsystem ls_subsystem_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_type  (mem_type),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .done      (done),
        .load_data (load_data),
        .err       (err)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic next_rand_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_rand_bit()};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string what, input word_t exp, input word_t act);
        $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        start_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - start_errors);
        end
    endtask

    // drives one operation and checks it against the reference memory.
    task automatic issue_op(input mem_type_t kind, input word_t a, input word_t b,
                            input word_t off, input bit hold);
        word_t                 addr;
        logic [DMEM_IDX_W-1:0] idx;
        logic                  in_range;
        word_t                 exp_data;
        int                    exp_lat;
        int                    cycles;
        logic                  done_seen;
        if (timed_out) begin
            return;
        end
        addr     = a + off;
        in_range = (addr < word_t'(DMEM_WORDS * 4));
        idx      = addr[DMEM_IDX_W+1:2];
        exp_lat  = 2 + SRAM_WAIT;
        mem_type = kind;
        rs1      = a;
        rs2      = b;
        imm      = off;
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < DONE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            done_seen = done;
        end
        if (!done_seen) begin
            $display("timeout: done did not arrive within %0d cycles in test %s",
                     DONE_TIMEOUT, test_name);
            errors++;
            timed_out = 1'b1;
            return;
        end
        last_data = load_data;
        last_err  = err;
        if (cycles != exp_lat) begin
            report_mismatch("latency", word_t'(exp_lat), word_t'(cycles));
        end
        if (last_err !== !in_range) begin
            report_mismatch("err", word_t'(!in_range), word_t'(last_err));
        end
        if (kind == LOAD) begin
            exp_data = in_range ? ref_mem[idx] : '0;
            if (last_data !== exp_data) begin
                report_mismatch("load_data", exp_data, last_data);
            end
        end else if (in_range) begin
            ref_mem[idx] = b;
        end
        // the next operation or NONE comes in the cycle after done.
        @(negedge CLK);
        if (!hold) begin
            mem_type = NONE;
            @(negedge CLK);
        end
    endtask

    task automatic test_reset_idle();
        begin_test("reset_idle");
        for (int i = 0; i < 8; i++) begin
            @(negedge CLK);
            if (done !== 1'b0) begin
                report_mismatch("done", '0, word_t'(done));
            end
            if (err !== 1'b0) begin
                report_mismatch("err", '0, word_t'(err));
            end
        end
        end_test();
    endtask

    task automatic store_then_load(input word_t a, input word_t off, input word_t data);
        issue_op(STORE, a, data, off, 1'b0);
        issue_op(LOAD, a, '0, off, 1'b0);
        if (last_data !== data) begin
            report_mismatch("stored word", data, last_data);
        end
    endtask

    task automatic test_store_load_imm();
        begin_test("store_load_imm");
        store_then_load(32'h0000_0100, 32'h0000_0024, 32'h1234_5678);
        store_then_load(32'h0000_02c0, 32'h0000_0000, 32'h0bad_f00d);
        store_then_load(32'h0000_0310, 32'hffff_fff0, 32'ha5a5_5a5a);
        // wraps past 2^32 to byte address 0x40.
        store_then_load(32'hffff_ff00, 32'h0000_0140, 32'h7e57_0040);
        end_test();
    endtask

    task automatic test_random_ops();
        mem_type_t kind;
        word_t     word_index;
        word_t     r;
        word_t     off;
        word_t     base;
        word_t     data;
        begin_test("random_ops");
        for (int k = 0; k < 40; k++) begin
            kind = next_rand_bit() ? STORE : LOAD;
            // small window of words so that loads hit earlier stores.
            word_index = 32'h40 + rand_bits(4);
            r    = rand_bits(12);
            off  = {{20{r[11]}}, r[11:0]};
            base = (word_index << 2) + rand_bits(2) - off;
            data = rand_bits(32);
            issue_op(kind, base, data, off, 1'b0);
        end
        end_test();
    endtask

    task automatic test_out_of_range();
        begin_test("out_of_range");
        issue_op(STORE, 32'h0000_0014, 32'hcafe_0014, '0, 1'b0);
        issue_op(LOAD, 32'h0000_0400, '0, '0, 1'b0);
        issue_op(LOAD, 32'h8000_0000, '0, 32'h0000_0010, 1'b0);
        // one memory size above 0x14 with the same word index.
        issue_op(STORE, 32'h0000_0400, 32'hdead_beef, 32'h0000_0014, 1'b0);
        if (last_err !== 1'b1) begin
            report_mismatch("store err", 32'h1, word_t'(last_err));
        end
        issue_op(LOAD, 32'h0000_0010, '0, 32'h0000_0004, 1'b0);
        if (last_data !== 32'hcafe_0014) begin
            report_mismatch("old word", 32'hcafe_0014, last_data);
        end
        end_test();
    endtask

    task automatic test_latency();
        begin_test("latency");
        for (int k = 0; k < 6; k++) begin
            repeat (k % 3) @(negedge CLK);
            if (k % 2 == 0) begin
                issue_op(STORE, 32'h0000_0200 + word_t'(k * 4), 32'h5100_0000 + word_t'(k),
                         '0, 1'b0);
            end else begin
                issue_op(LOAD, 32'h0000_01fc + word_t'(k * 4), '0, '0, 1'b0);
            end
        end
        end_test();
    endtask

    task automatic test_back_to_back();
        begin_test("back_to_back");
        issue_op(STORE, 32'h0000_0080, 32'hb2b0_0001, '0, 1'b1);
        issue_op(STORE, 32'h0000_0084, 32'hb2b0_0002, '0, 1'b1);
        issue_op(STORE, 32'h0000_0088, 32'hb2b0_0003, '0, 1'b1);
        issue_op(LOAD, 32'h0000_0080, '0, '0, 1'b1);
        if (last_data !== 32'hb2b0_0001) begin
            report_mismatch("first load", 32'hb2b0_0001, last_data);
        end
        issue_op(LOAD, 32'h0000_0084, '0, '0, 1'b1);
        if (last_data !== 32'hb2b0_0002) begin
            report_mismatch("second load", 32'hb2b0_0002, last_data);
        end
        issue_op(LOAD, 32'h0000_0088, '0, '0, 1'b0);
        if (last_data !== 32'hb2b0_0003) begin
            report_mismatch("third load", 32'hb2b0_0003, last_data);
        end
        end_test();
    endtask

    initial begin
        nRST         = 1'b0;
        mem_type     = NONE;
        rs1          = '0;
        rs2          = '0;
        imm          = '0;
        lfsr_state   = 32'd81050;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (10) @(negedge CLK);
        nRST = 1'b1;
        test_reset_idle();
        test_store_load_imm();
        test_random_ops();
        test_out_of_range();
        test_latency();
        test_back_to_back();
        errors = errors + int'(ls_subsystem_i.bridge_i.props_i.violations);
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/lsu_pkg.sv
src/dmem_if.sv
src/apb_if.sv
src/scalar_ls_unit.sv
src/dmem_apb_master.sv
src/apb_sram.sv
src/ls_subsystem.sv
sim/ls_subsystem_properties.sv
sim/ls_subsystem_tb.sv

/* Makefile */
# Verilator build and run for the load/store subsystem.

VERILATOR ?= verilator
TOP       ?= ls_subsystem_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert

EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(EXE) > $(LOG) 2>&1
	cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
